/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = lce_req_tb
FILELIST   = sources.f
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* include/lce_macros.svh */
// build parameters of the cache engine request path
// address, data and id widths, credits and metadata timing

`ifndef LCE_MACROS_SVH
`define LCE_MACROS_SVH

// physical address and data widths
`define LCE_PADDR_WIDTH 32
`define LCE_FILL_WIDTH 64
`define LCE_BLOCK_WIDTH 256

// outstanding request limit
`define LCE_CREDITS 4

// engine and directory ids
`define LCE_ID_WIDTH 4
`define LCE_CCE_ID_WIDTH 2

// associativity and the width of a way id
`define LCE_ASSOC 4
`define LCE_WAY_WIDTH $clog2(`LCE_ASSOC)

// metadata follows the request by 0 or 1 cycles
`define LCE_METADATA_LATENCY 1

// 1 makes read misses ask for non-exclusive state
`define LCE_NON_EXCL_READS 0

`endif

/* sim/lce_req_tb.sv */
// testbench for the cache engine request path
// table of requests with expected headers, network sink model,
// completion pulses and typed compare tasks

`timescale 1ns/100ps

`include "lce_macros.svh"

module lce_req_tb
  import cache_if_pkg::*;
  import bedrock_req_pkg::*;
();

  localparam int num_entries_lp = 15;
  localparam int timeout_lp = 200;
  localparam logic [`LCE_ID_WIDTH-1:0] lce_id_lp = 4'ha;

  typedef struct packed {
    cache_req_kind_e             kind;
    logic [`LCE_PADDR_WIDTH-1:0] addr;
    cache_req_size_e             size;
    cache_amo_op_e               amo;
    logic [`LCE_FILL_WIDTH-1:0]  data;
    logic [`LCE_WAY_WIDTH-1:0]   way;
    bedrock_req_header_s         exp_header;
    logic                        check_data;
  } req_entry_s;

  logic                        clk_i = 1'b0;
  logic                        reset_i;
  logic [`LCE_ID_WIDTH-1:0]    lce_id_i;
  lce_mode_e                   lce_mode_i;
  logic                        cache_init_done_i;
  logic                        sync_done_i;
  logic                        cache_req_v_i;
  cache_req_kind_e             cache_req_kind_i;
  logic [`LCE_PADDR_WIDTH-1:0] cache_req_addr_i;
  cache_req_size_e             cache_req_size_i;
  cache_amo_op_e               cache_req_amo_op_i;
  logic [`LCE_FILL_WIDTH-1:0]  cache_req_data_i;
  logic                        cache_req_metadata_v_i;
  logic [`LCE_WAY_WIDTH-1:0]   cache_req_way_i;
  logic                        cache_req_complete_i;
  logic                        uc_store_complete_i;
  logic                        lce_req_ready_i;
  logic                        cache_req_ready_o;
  logic                        busy_o;
  logic                        credits_full_o;
  logic                        credits_empty_o;
  bedrock_req_header_s         lce_req_header_o;
  logic [`LCE_FILL_WIDTH-1:0]  lce_req_data_o;
  logic                        lce_req_v_o;
  logic                        lce_req_last_o;

  integer                      seed;
  req_entry_s                  table_mem [0:num_entries_lp-1];
  bedrock_req_header_s         exp_header_q [$];
  logic [`LCE_FILL_WIDTH-1:0]  exp_data_q [$];
  logic                        exp_check_q [$];
  logic                        sink_random;
  logic                        auto_complete;
  logic                        taken_prev;
  logic                        hold_prev;
  bedrock_req_header_s         held_header;

  lce_req_top DUT (.*);

  always #20 clk_i = ~clk_i;

  task automatic abort_run;
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_header(input string name, input bedrock_req_header_s got,
                                input bedrock_req_header_s exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_data(input string name, input logic [`LCE_FILL_WIDTH-1:0] got,
                              input logic [`LCE_FILL_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // network subop for each cache atomic
  function automatic bedrock_wr_subop_e subop_for(input cache_amo_op_e op);
    case (op)
      e_amo_lr:   subop_for = e_bedrock_amolr;
      e_amo_sc:   subop_for = e_bedrock_amosc;
      e_amo_swap: subop_for = e_bedrock_amoswap;
      e_amo_add:  subop_for = e_bedrock_amoadd;
      e_amo_xor:  subop_for = e_bedrock_amoxor;
      e_amo_and:  subop_for = e_bedrock_amoand;
      e_amo_or:   subop_for = e_bedrock_amoor;
      e_amo_min:  subop_for = e_bedrock_amomin;
      e_amo_max:  subop_for = e_bedrock_amomax;
      e_amo_minu: subop_for = e_bedrock_amominu;
      e_amo_maxu: subop_for = e_bedrock_amomaxu;
      default:    subop_for = e_bedrock_store;
    endcase
  endfunction

  function automatic req_entry_s make_entry(input cache_req_kind_e kind,
                                            input logic [`LCE_PADDR_WIDTH-1:0] addr,
                                            input cache_req_size_e size,
                                            input cache_amo_op_e amo,
                                            input logic [`LCE_FILL_WIDTH-1:0] data,
                                            input logic [`LCE_WAY_WIDTH-1:0] way);
    req_entry_s e;
    e = '0;
    e.kind = kind;
    e.addr = addr;
    e.size = size;
    e.amo  = amo;
    e.data = data;
    e.way  = way;
    e.check_data = (kind == e_miss_store) || (kind == e_uc_store) || (kind == e_uc_amo);
    e.exp_header.size   = size;
    e.exp_header.src_id = lce_id_lp;
    // directory id sits just above the 32-byte block offset
    e.exp_header.dst_id = addr[6:5];
    e.exp_header.addr   = addr;
    case (kind)
      e_miss_load: begin
        e.exp_header.msg_type          = e_bedrock_req_rd_miss;
        e.exp_header.addr              = {addr[31:3], 3'b000};
        e.exp_header.aux.miss.way_id   = way;
        e.exp_header.aux.miss.non_excl = 1'(`LCE_NON_EXCL_READS);
      end
      e_miss_store: begin
        e.exp_header.msg_type        = e_bedrock_req_wr_miss;
        e.exp_header.addr            = {addr[31:3], 3'b000};
        e.exp_header.aux.miss.way_id = way;
      end
      e_uc_load: begin
        e.exp_header.msg_type = e_bedrock_req_uc_rd;
        e.exp_header.aux.uc   = e_bedrock_store;
      end
      e_uc_store: begin
        e.exp_header.msg_type = e_bedrock_req_uc_wr;
        e.exp_header.aux.uc   = e_bedrock_store;
      end
      default: begin
        e.exp_header.msg_type = e_bedrock_req_uc_amo;
        e.exp_header.aux.uc   = subop_for(amo);
      end
    endcase
    return e;
  endfunction

  task automatic build_table;
    logic [31:0] rnd_addr;
    logic [31:0] rnd_hi;
    logic [31:0] rnd_lo;
    table_mem[0] = make_entry(e_miss_load, 32'h8000_1a6c, e_size_8b, e_amo_lr, 64'h0, 2'd2);
    table_mem[1] = make_entry(e_miss_store, 32'h8000_0f54, e_size_8b, e_amo_lr,
                              64'h0123_4567_89ab_cdef, 2'd1);
    table_mem[2] = make_entry(e_uc_load, 32'h1000_0047, e_size_1b, e_amo_lr, 64'h0, 2'd0);
    table_mem[3] = make_entry(e_uc_store, 32'h1000_0124, e_size_4b, e_amo_lr,
                              64'h0000_0000_5a5a_c3c3, 2'd0);
    // one atomic of each kind at a random aligned address
    for (int i = 0; i < 11; i++) begin
      rnd_addr = $random(seed);
      rnd_hi = $random(seed);
      rnd_lo = $random(seed);
      table_mem[4 + i] = make_entry(e_uc_amo, {rnd_addr[31:3], 3'b000},
                                    rnd_lo[0] ? e_size_8b : e_size_4b,
                                    cache_amo_op_e'(4'(i)), {rnd_hi, rnd_lo}, 2'd0);
    end
  endtask

  // md_delay counts cycles from acceptance to the metadata strobe
  task automatic send_request(input int idx, input int md_delay);
    req_entry_s e;
    int         waited;
    e = table_mem[idx];
    exp_header_q.push_back(e.exp_header);
    exp_data_q.push_back(e.data);
    exp_check_q.push_back(e.check_data);
    @(negedge clk_i);
    cache_req_v_i      = 1'b1;
    cache_req_kind_i   = e.kind;
    cache_req_addr_i   = e.addr;
    cache_req_size_i   = e.size;
    cache_req_amo_op_i = e.amo;
    cache_req_data_i   = e.data;
    #1;
    waited = 0;
    while (!cache_req_ready_o) begin
      @(negedge clk_i);
      #1;
      waited++;
      if (waited > timeout_lp) begin
        $display("timeout: cache_req_ready_o never rose for entry %0d", idx);
        abort_run();
      end
    end
    @(negedge clk_i);
    cache_req_v_i = 1'b0;
    if (e.kind == e_miss_load || e.kind == e_miss_store) begin
      // a miss must stay off the network until its way arrives
      repeat (md_delay - 1) begin
        #1;
        compare_flag("lce_req_v_o", lce_req_v_o, 1'b0);
        @(negedge clk_i);
      end
      cache_req_metadata_v_i = 1'b1;
      cache_req_way_i        = e.way;
      @(negedge clk_i);
      cache_req_metadata_v_i = 1'b0;
    end
  endtask

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while (exp_header_q.size() != 0) begin
      @(negedge clk_i);
      #2;
      waited++;
      if (waited > limit) begin
        $display("timeout: %0d requests never left on the network", exp_header_q.size());
        abort_run();
      end
    end
  endtask

  task automatic wait_credits_empty(input int limit);
    int waited;
    waited = 0;
    while (!credits_empty_o) begin
      @(negedge clk_i);
      #2;
      waited++;
      if (waited > limit) begin
        $display("timeout: credits never returned to empty");
        abort_run();
      end
    end
  endtask

  // sink model, completion pulses and checks of every network beat
  always @(negedge clk_i) begin : network_sink
    logic [31:0]                rnd;
    bedrock_req_header_s        exp_h;
    logic [`LCE_FILL_WIDTH-1:0] exp_d;
    logic                       exp_chk;
    cache_req_complete_i = auto_complete & taken_prev;
    rnd = $random(seed);
    lce_req_ready_i = sink_random ? rnd[0] : 1'b1;
    #1;
    if (hold_prev) begin
      compare_flag("lce_req_v_o", lce_req_v_o, 1'b1);
      compare_header("lce_req_header_o", lce_req_header_o, held_header);
    end
    if (lce_req_v_o) begin
      compare_flag("lce_req_last_o", lce_req_last_o, 1'b1);
    end
    taken_prev = lce_req_v_o & lce_req_ready_i;
    if (taken_prev) begin
      if (exp_header_q.size() == 0) begin
        $display("a beat left on the network with no request outstanding");
        abort_run();
      end
      exp_h = exp_header_q.pop_front();
      exp_d = exp_data_q.pop_front();
      exp_chk = exp_check_q.pop_front();
      compare_header("lce_req_header_o", lce_req_header_o, exp_h);
      if (exp_chk) begin
        compare_data("lce_req_data_o", lce_req_data_o, exp_d);
      end
    end
    hold_prev = lce_req_v_o & ~lce_req_ready_i;
    held_header = lce_req_header_o;
  end

  initial begin
    seed = 32'h0d3c87b1;
    reset_i = 1'b1;
    lce_id_i = lce_id_lp;
    lce_mode_i = e_lce_mode_uncached;
    cache_init_done_i = 1'b0;
    sync_done_i = 1'b0;
    cache_req_v_i = 1'b0;
    cache_req_kind_i = e_miss_load;
    cache_req_addr_i = '0;
    cache_req_size_i = e_size_8b;
    cache_req_amo_op_i = e_amo_lr;
    cache_req_data_i = '0;
    cache_req_metadata_v_i = 1'b0;
    cache_req_way_i = '0;
    cache_req_complete_i = 1'b0;
    uc_store_complete_i = 1'b0;
    lce_req_ready_i = 1'b0;
    sink_random = 1'b0;
    auto_complete = 1'b1;
    taken_prev = 1'b0;
    hold_prev = 1'b0;
    held_header = '0;
    build_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    compare_flag("busy_o", busy_o, 1'b1);
    compare_flag("lce_req_v_o", lce_req_v_o, 1'b0);
    compare_flag("credits_full_o", credits_full_o, 1'b0);

    // init, then the sync handshake in normal mode
    @(negedge clk_i);
    cache_init_done_i = 1'b1;
    @(negedge clk_i);
    #1;
    compare_flag("busy_o", busy_o, 1'b0);
    @(negedge clk_i);
    lce_mode_i = e_lce_mode_normal;
    #1;
    compare_flag("busy_o", busy_o, 1'b1);
    @(negedge clk_i);
    sync_done_i = 1'b1;
    #1;
    compare_flag("busy_o", busy_o, 1'b0);

    // whole table under random back-pressure
    sink_random = 1'b1;
    for (int i = 0; i < num_entries_lp; i++) begin
      send_request(i, 1);
    end
    wait_drain(timeout_lp);
    sink_random = 1'b0;
    wait_credits_empty(timeout_lp);

    // late metadata holds a miss while an uncached request goes straight through
    send_request(0, 5);
    wait_drain(timeout_lp);
    send_request(2, 1);
    wait_drain(3);
    wait_credits_empty(timeout_lp);

    // five requests against four credits
    auto_complete = 1'b0;
    for (int i = 2; i < 6; i++) begin
      send_request(i, 1);
    end
    wait_drain(timeout_lp);
    send_request(6, 1);
    repeat (3) begin
      #1;
      compare_flag("credits_full_o", credits_full_o, 1'b1);
      compare_flag("credits_empty_o", credits_empty_o, 1'b0);
      compare_flag("cache_req_ready_o", cache_req_ready_o, 1'b0);
      compare_flag("lce_req_v_o", lce_req_v_o, 1'b0);
      @(negedge clk_i);
    end
    uc_store_complete_i = 1'b1;
    @(negedge clk_i);
    uc_store_complete_i = 1'b0;
    wait_drain(timeout_lp);
    @(negedge clk_i);
    uc_store_complete_i = 1'b1;
    repeat (4) @(negedge clk_i);
    uc_store_complete_i = 1'b0;
    wait_credits_empty(timeout_lp);

    if (exp_header_q.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("requests were sent but never seen on the network");
      abort_run();
    end
  end

endmodule

/* source/bedrock_req_pkg.sv */
// network side request types
// message type, write subop, aux union, header and engine mode

package bedrock_req_pkg;

  `include "lce_macros.svh"

  typedef enum logic [2:0] {
    e_bedrock_req_rd_miss = 3'd0,
    e_bedrock_req_wr_miss = 3'd1,
    e_bedrock_req_uc_rd   = 3'd2,
    e_bedrock_req_uc_wr   = 3'd3,
    e_bedrock_req_uc_amo  = 3'd4
  } bedrock_req_type_e;

  // plain store, or the atomic carried by an uncached atomic
  typedef enum logic [3:0] {
    e_bedrock_store   = 4'd0,
    e_bedrock_amolr   = 4'd1,
    e_bedrock_amosc   = 4'd2,
    e_bedrock_amoswap = 4'd3,
    e_bedrock_amoadd  = 4'd4,
    e_bedrock_amoxor  = 4'd5,
    e_bedrock_amoand  = 4'd6,
    e_bedrock_amoor   = 4'd7,
    e_bedrock_amomin  = 4'd8,
    e_bedrock_amomax  = 4'd9,
    e_bedrock_amominu = 4'd10,
    e_bedrock_amomaxu = 4'd11
  } bedrock_wr_subop_e;

  localparam int aux_pad_width_lp = 4 - 1 - `LCE_WAY_WIDTH;

  // miss view of the aux field
  typedef struct packed {
    logic [aux_pad_width_lp-1:0] pad;
    logic                        non_excl;
    logic [`LCE_WAY_WIDTH-1:0]   way_id;
  } bedrock_req_miss_aux_s;

  // misses read the miss view and uncached requests the uc view
  typedef union packed {
    bedrock_req_miss_aux_s miss;
    bedrock_wr_subop_e     uc;
  } bedrock_req_aux_u;

  typedef struct packed {
    bedrock_req_type_e              msg_type;
    logic [`LCE_PADDR_WIDTH-1:0]    addr;
    logic [2:0]                     size;
    bedrock_req_aux_u               aux;
    logic [`LCE_ID_WIDTH-1:0]       src_id;
    logic [`LCE_CCE_ID_WIDTH-1:0]   dst_id;
  } bedrock_req_header_s;

  typedef enum logic {
    e_lce_mode_uncached = 1'b0,
    e_lce_mode_normal   = 1'b1
  } lce_mode_e;

endpackage

/* source/cache_if_pkg.sv */
// cache side request types
// request kind, atomic operation and request size

package cache_if_pkg;

  // what the cache asks for
  typedef enum logic [2:0] {
    e_miss_load  = 3'd0,
    e_miss_store = 3'd1,
    e_uc_load    = 3'd2,
    e_uc_store   = 3'd3,
    e_uc_amo     = 3'd4
  } cache_req_kind_e;

  // atomic operation of an uncached atomic request
  typedef enum logic [3:0] {
    e_amo_lr   = 4'd0,
    e_amo_sc   = 4'd1,
    e_amo_swap = 4'd2,
    e_amo_add  = 4'd3,
    e_amo_xor  = 4'd4,
    e_amo_and  = 4'd5,
    e_amo_or   = 4'd6,
    e_amo_min  = 4'd7,
    e_amo_max  = 4'd8,
    e_amo_minu = 4'd9,
    e_amo_maxu = 4'd10
  } cache_amo_op_e;

  // log2 of the size in bytes
  typedef enum logic [2:0] {
    e_size_1b  = 3'd0,
    e_size_2b  = 3'd1,
    e_size_4b  = 3'd2,
    e_size_8b  = 3'd3,
    e_size_16b = 3'd4,
    e_size_32b = 3'd5
  } cache_req_size_e;

endpackage

/* source/cache_req_capture.sv */
// cache request capture stage
// holds one request with its metadata and drives ready to the cache

`timescale 1ns/100ps

`include "lce_macros.svh"

module cache_req_capture
  import cache_if_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         cache_req_v_i,
  input  cache_req_kind_e              cache_req_kind_i,
  input  logic [`LCE_PADDR_WIDTH-1:0]  cache_req_addr_i,
  input  cache_req_size_e              cache_req_size_i,
  input  cache_amo_op_e                cache_req_amo_op_i,
  input  logic [`LCE_FILL_WIDTH-1:0]   cache_req_data_i,
  input  logic                         cache_req_metadata_v_i,
  input  logic [`LCE_WAY_WIDTH-1:0]    cache_req_way_i,
  input  logic                         req_sent_i,
  output logic                         cache_req_ready_o,
  output logic                         held_v_o,
  output cache_req_kind_e              held_kind_o,
  output logic [`LCE_PADDR_WIDTH-1:0]  held_addr_o,
  output cache_req_size_e              held_size_o,
  output cache_amo_op_e                held_amo_op_o,
  output logic [`LCE_FILL_WIDTH-1:0]   held_data_o,
  output logic [`LCE_WAY_WIDTH-1:0]    held_way_o,
  output logic                         metadata_ready_o
);

  localparam bit md_with_req_lp = (`LCE_METADATA_LATENCY == 0);

  logic                      accept;
  logic                      md_seen_r;
  logic [`LCE_WAY_WIDTH-1:0] way_r;

  // a new request may enter on the edge that sends the held one
  assign cache_req_ready_o = ~held_v_o | req_sent_i;
  assign accept = cache_req_v_i & cache_req_ready_o;

  // set wins over clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      held_v_o <= 1'b0;
    end else if (accept) begin
      held_v_o <= 1'b1;
    end else if (req_sent_i) begin
      held_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      held_kind_o   <= cache_req_kind_i;
      held_addr_o   <= cache_req_addr_i;
      held_size_o   <= cache_req_size_i;
      held_amo_op_o <= cache_req_amo_op_i;
      held_data_o   <= cache_req_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_req_metadata_v_i) begin
      way_r <= cache_req_way_i;
    end
  end

  // with latency 1 a strobe on the accept edge belongs to the previous request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      md_seen_r <= 1'b0;
    end else if (accept) begin
      md_seen_r <= md_with_req_lp & cache_req_metadata_v_i;
    end else if (cache_req_metadata_v_i) begin
      md_seen_r <= 1'b1;
    end
  end

  // metadata bypasses the register in the cycle it arrives
  assign held_way_o = cache_req_metadata_v_i ? cache_req_way_i : way_r;
  assign metadata_ready_o = md_seen_r | cache_req_metadata_v_i;

  // uncached traffic fits in one 64-bit beat
  a_uc_size: assert property (@(posedge clk_i) disable iff (reset_i)
    held_v_o && (held_kind_o inside {e_uc_load, e_uc_store, e_uc_amo})
      |-> held_size_o <= e_size_8b);

endmodule

/* source/lce_req_encoder.sv */
// request encoder with init FSM and credit counter
// translates the held cache request into a network header and beat

`timescale 1ns/100ps

`include "lce_macros.svh"

module lce_req_encoder
  import cache_if_pkg::*;
  import bedrock_req_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [`LCE_ID_WIDTH-1:0]     lce_id_i,
  input  lce_mode_e                    lce_mode_i,
  input  logic                         cache_init_done_i,
  input  logic                         sync_done_i,
  input  logic                         held_v_i,
  input  cache_req_kind_e              held_kind_i,
  input  logic [`LCE_PADDR_WIDTH-1:0]  held_addr_i,
  input  cache_req_size_e              held_size_i,
  input  cache_amo_op_e                held_amo_op_i,
  input  logic [`LCE_FILL_WIDTH-1:0]   held_data_i,
  input  logic [`LCE_WAY_WIDTH-1:0]    held_way_i,
  input  logic                         metadata_ready_i,
  input  logic                         queue_full_i,
  input  logic                         cache_req_complete_i,
  input  logic                         uc_store_complete_i,
  output logic                         req_sent_o,
  output logic                         push_o,
  output bedrock_req_header_s          push_header_o,
  output logic [`LCE_FILL_WIDTH-1:0]   push_data_o,
  output logic                         busy_o,
  output logic                         credits_full_o,
  output logic                         credits_empty_o
);

  localparam int credit_width_lp = $clog2(`LCE_CREDITS + 1);
  localparam logic [credit_width_lp-1:0] credit_max_lp = `LCE_CREDITS;
  localparam int beat_offset_lp = $clog2(`LCE_FILL_WIDTH / 8);
  localparam int block_offset_lp = $clog2(`LCE_BLOCK_WIDTH / 8);
  localparam logic [`LCE_PADDR_WIDTH-1:0] beat_mask_lp = {`LCE_PADDR_WIDTH{1'b1}} << beat_offset_lp;

  typedef enum logic {
    e_init,
    e_ready
  } state_e;

  state_e                     state_r;
  logic [credit_width_lp-1:0] credit_count_r;
  logic [1:0]                 credit_returns;
  logic                       is_miss;
  bedrock_wr_subop_e          amo_subop;

  // wait for the cache arrays to finish initializing
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_init;
    end else if (state_r == e_init && cache_init_done_i) begin
      state_r <= e_ready;
    end
  end

  assign busy_o = (state_r == e_init) || (~sync_done_i && (lce_mode_i == e_lce_mode_normal));

  assign is_miss = held_kind_i inside {e_miss_load, e_miss_store};

  // misses also need their replacement way
  assign push_o = (state_r == e_ready) && held_v_i && (credit_count_r < credit_max_lp)
                  && ~queue_full_i && (~is_miss || metadata_ready_i);
  assign req_sent_o = push_o;

  // one credit per request, one back per completion pulse
  assign credit_returns = {1'b0, cache_req_complete_i} + {1'b0, uc_store_complete_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_count_r <= '0;
    end else begin
      credit_count_r <= credit_count_r + credit_width_lp'(push_o)
                        - credit_width_lp'(credit_returns);
    end
  end

  assign credits_full_o  = held_v_i && (credit_count_r == credit_max_lp);
  assign credits_empty_o = ~held_v_i && (credit_count_r == '0);

  always_comb begin
    unique case (held_amo_op_i)
      e_amo_lr:   amo_subop = e_bedrock_amolr;
      e_amo_sc:   amo_subop = e_bedrock_amosc;
      e_amo_swap: amo_subop = e_bedrock_amoswap;
      e_amo_add:  amo_subop = e_bedrock_amoadd;
      e_amo_xor:  amo_subop = e_bedrock_amoxor;
      e_amo_and:  amo_subop = e_bedrock_amoand;
      e_amo_or:   amo_subop = e_bedrock_amoor;
      e_amo_min:  amo_subop = e_bedrock_amomin;
      e_amo_max:  amo_subop = e_bedrock_amomax;
      e_amo_minu: amo_subop = e_bedrock_amominu;
      e_amo_maxu: amo_subop = e_bedrock_amomaxu;
      default:    amo_subop = e_bedrock_store;
    endcase
  end

  always_comb begin
    push_header_o        = '0;
    push_header_o.size   = held_size_i;
    push_header_o.src_id = lce_id_i;
    // directory chosen by the address bits above the block offset
    push_header_o.dst_id = held_addr_i[block_offset_lp +: `LCE_CCE_ID_WIDTH];
    // uncached requests carry the full byte address
    push_header_o.addr   = held_addr_i;
    unique case (held_kind_i)
      e_miss_load: begin
        push_header_o.msg_type             = e_bedrock_req_rd_miss;
        push_header_o.addr                 = held_addr_i & beat_mask_lp;
        push_header_o.aux.miss.way_id      = held_way_i;
        push_header_o.aux.miss.non_excl    = 1'(`LCE_NON_EXCL_READS);
      end
      e_miss_store: begin
        push_header_o.msg_type             = e_bedrock_req_wr_miss;
        push_header_o.addr                 = held_addr_i & beat_mask_lp;
        push_header_o.aux.miss.way_id      = held_way_i;
        push_header_o.aux.miss.non_excl    = 1'b0;
      end
      e_uc_load: begin
        push_header_o.msg_type = e_bedrock_req_uc_rd;
        push_header_o.aux.uc   = e_bedrock_store;
      end
      e_uc_store: begin
        push_header_o.msg_type = e_bedrock_req_uc_wr;
        push_header_o.aux.uc   = e_bedrock_store;
      end
      e_uc_amo: begin
        push_header_o.msg_type = e_bedrock_req_uc_amo;
        push_header_o.aux.uc   = amo_subop;
      end
      default: begin
        push_header_o.msg_type = e_bedrock_req_uc_rd;
      end
    endcase
  end

  assign push_data_o = held_data_i;

  // completions only come back for requests already sent
  a_credit_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_req_complete_i || uc_store_complete_i)
      |-> credit_width_lp'(credit_returns) <= credit_count_r);

endmodule

/* source/lce_req_out_queue.sv */
// two-entry output queue toward the network
// single-beat messages, so last follows valid

`timescale 1ns/100ps

`include "lce_macros.svh"

module lce_req_out_queue
  import bedrock_req_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        push_i,
  input  bedrock_req_header_s         push_header_i,
  input  logic [`LCE_FILL_WIDTH-1:0]  push_data_i,
  input  logic                        lce_req_ready_i,
  output logic                        queue_full_o,
  output bedrock_req_header_s         lce_req_header_o,
  output logic [`LCE_FILL_WIDTH-1:0]  lce_req_data_o,
  output logic                        lce_req_v_o,
  output logic                        lce_req_last_o
);

  bedrock_req_header_s        header_mem [0:1];
  logic [`LCE_FILL_WIDTH-1:0] data_mem [0:1];
  // top bit of each pointer tells full from empty
  logic [1:0]                 wr_ptr_r;
  logic [1:0]                 rd_ptr_r;
  logic                       pop;

  assign queue_full_o = (wr_ptr_r[1] != rd_ptr_r[1]) && (wr_ptr_r[0] == rd_ptr_r[0]);
  assign lce_req_v_o  = (wr_ptr_r != rd_ptr_r);
  assign pop          = lce_req_v_o & lce_req_ready_i;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      header_mem[wr_ptr_r[0]] <= push_header_i;
      data_mem[wr_ptr_r[0]]   <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      wr_ptr_r <= wr_ptr_r + 2'(push_i);
      rd_ptr_r <= rd_ptr_r + 2'(pop);
    end
  end

  // head entry stays put until the network takes it
  assign lce_req_header_o = header_mem[rd_ptr_r[0]];
  assign lce_req_data_o   = data_mem[rd_ptr_r[0]];
  assign lce_req_last_o   = lce_req_v_o;

  // the encoder must respect full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    queue_full_o |-> !push_i);

endmodule

/* source/lce_req_top.sv */
// request path of the local cache engine
// capture, encoder and output queue

`timescale 1ns/100ps

`include "lce_macros.svh"

module lce_req_top
  import cache_if_pkg::*;
  import bedrock_req_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [`LCE_ID_WIDTH-1:0]     lce_id_i,
  input  lce_mode_e                    lce_mode_i,
  input  logic                         cache_init_done_i,
  input  logic                         sync_done_i,
  input  logic                         cache_req_v_i,
  input  cache_req_kind_e              cache_req_kind_i,
  input  logic [`LCE_PADDR_WIDTH-1:0]  cache_req_addr_i,
  input  cache_req_size_e              cache_req_size_i,
  input  cache_amo_op_e                cache_req_amo_op_i,
  input  logic [`LCE_FILL_WIDTH-1:0]   cache_req_data_i,
  input  logic                         cache_req_metadata_v_i,
  input  logic [`LCE_WAY_WIDTH-1:0]    cache_req_way_i,
  input  logic                         cache_req_complete_i,
  input  logic                         uc_store_complete_i,
  input  logic                         lce_req_ready_i,
  output logic                         cache_req_ready_o,
  output logic                         busy_o,
  output logic                         credits_full_o,
  output logic                         credits_empty_o,
  output bedrock_req_header_s          lce_req_header_o,
  output logic [`LCE_FILL_WIDTH-1:0]   lce_req_data_o,
  output logic                         lce_req_v_o,
  output logic                         lce_req_last_o
);

  logic                        held_v;
  cache_req_kind_e             held_kind;
  logic [`LCE_PADDR_WIDTH-1:0] held_addr;
  cache_req_size_e             held_size;
  cache_amo_op_e               held_amo_op;
  logic [`LCE_FILL_WIDTH-1:0]  held_data;
  logic [`LCE_WAY_WIDTH-1:0]   held_way;
  logic                        metadata_ready;
  logic                        req_sent;
  logic                        push;
  bedrock_req_header_s         push_header;
  logic [`LCE_FILL_WIDTH-1:0]  push_data;
  logic                        queue_full;

  cache_req_capture capture (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cache_req_v_i(cache_req_v_i),
    .cache_req_kind_i(cache_req_kind_i),
    .cache_req_addr_i(cache_req_addr_i),
    .cache_req_size_i(cache_req_size_i),
    .cache_req_amo_op_i(cache_req_amo_op_i),
    .cache_req_data_i(cache_req_data_i),
    .cache_req_metadata_v_i(cache_req_metadata_v_i),
    .cache_req_way_i(cache_req_way_i),
    .req_sent_i(req_sent),
    .cache_req_ready_o(cache_req_ready_o),
    .held_v_o(held_v),
    .held_kind_o(held_kind),
    .held_addr_o(held_addr),
    .held_size_o(held_size),
    .held_amo_op_o(held_amo_op),
    .held_data_o(held_data),
    .held_way_o(held_way),
    .metadata_ready_o(metadata_ready)
  );

  lce_req_encoder encoder (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .lce_id_i(lce_id_i),
    .lce_mode_i(lce_mode_i),
    .cache_init_done_i(cache_init_done_i),
    .sync_done_i(sync_done_i),
    .held_v_i(held_v),
    .held_kind_i(held_kind),
    .held_addr_i(held_addr),
    .held_size_i(held_size),
    .held_amo_op_i(held_amo_op),
    .held_data_i(held_data),
    .held_way_i(held_way),
    .metadata_ready_i(metadata_ready),
    .queue_full_i(queue_full),
    .cache_req_complete_i(cache_req_complete_i),
    .uc_store_complete_i(uc_store_complete_i),
    .req_sent_o(req_sent),
    .push_o(push),
    .push_header_o(push_header),
    .push_data_o(push_data),
    .busy_o(busy_o),
    .credits_full_o(credits_full_o),
    .credits_empty_o(credits_empty_o)
  );

  lce_req_out_queue out_queue (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .push_i(push),
    .push_header_i(push_header),
    .push_data_i(push_data),
    .lce_req_ready_i(lce_req_ready_i),
    .queue_full_o(queue_full),
    .lce_req_header_o(lce_req_header_o),
    .lce_req_data_o(lce_req_data_o),
    .lce_req_v_o(lce_req_v_o),
    .lce_req_last_o(lce_req_last_o)
  );

endmodule

/* sources.f */
+incdir+include
source/cache_if_pkg.sv
source/bedrock_req_pkg.sv
source/cache_req_capture.sv
source/lce_req_encoder.sv
source/lce_req_out_queue.sv
source/lce_req_top.sv
sim/lce_req_tb.sv
